// File: conv_pkg.sv
package conv_pkg;

    // Output word of the engine
    localparam int RESULT_BITS = 8;             // Width of one result
    localparam int SAT_MAX     = 127;           // Results clip here

    // Result address, bounds pic_size * pic_size
    localparam int ADDR_BITS = 16;

    typedef logic [ADDR_BITS-1:0] addr_t;       // Raster address of a result

    // Side info that rides along with each window through the PE
    typedef struct packed {
        addr_t addr;                            // Raster address of the output pixel
        logic  last;                            // Final pixel of the frame
    } res_tag_t;

    // Saturated result with its tag
    typedef struct packed {
        logic [RESULT_BITS-1:0] data;           // Clipped sum
        res_tag_t               tag;            // Address and last flag
    } conv_result_t;

    // Controller sequence
    typedef enum logic [2:0] {
        IDLE,                                   // Waiting for conv_start
        LOAD_W,                                 // Kernel weights coming in
        FILL,                                   // Shift and load image rows
        CALC,                                   // Sweep windows over one row
        DRAIN                                   // Wait for the last result
    } ctrl_state_t;

endpackage

// File: weight_bank.sv
`timescale 1ns/1ps

module weight_bank #(
    parameter int weight_bits = 8,
    parameter int kernel_size = 5
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       w_load,
    input  logic                                       weight_data_valid,
    input  logic [weight_bits-1:0]                     weight_data,
    output logic [kernel_size*kernel_size*weight_bits-1:0] weights,
    output logic                                       w_full
);

    localparam int NW       = kernel_size * kernel_size;   // Weights per kernel
    localparam int CNT_BITS = $clog2(NW);

    logic [CNT_BITS-1:0] wr_cnt;                // Next slot in kernel raster order
    logic [CNT_BITS-1:0] wr_idx;
    logic                load_q;                // w_load one cycle back
    logic                load_rise;
    logic                full_q;
    logic                wr_en;

    assign load_rise = w_load && !load_q;               // New load opens
    assign wr_idx    = load_rise ? '0 : wr_cnt;          // Restart at slot 0 on a new load
    assign wr_en     = w_load && weight_data_valid && (load_rise || !full_q);
    assign w_full    = full_q && !load_rise;             // Stale full flag hidden on open

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            wr_cnt <= '0;
            full_q <= 1'b0;
        end else begin
            load_q <= w_load;
            if (load_rise) begin
                wr_cnt <= '0;
                full_q <= 1'b0;
            end
            if (wr_en) begin
                wr_cnt <= wr_idx + 1'b1;
                if (wr_idx == CNT_BITS'(NW - 1))
                    full_q <= 1'b1;                      // Last tap written
            end
        end
    end

    // Tap storage feeding the multiplier array
    always_ff @(posedge clk) begin
        if (wr_en)
            weights[wr_idx*weight_bits +: weight_bits] <= weight_data;
    end

endmodule

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
    parameter int pic_bits    = 8,
    parameter int kernel_size = 5,
    parameter int pic_size    = 28
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     lb_clear,
    input  logic                                     lb_shift,
    input  logic                                     lb_wr,
    input  logic [$clog2(pic_size)-1:0]              lb_col,
    input  logic [pic_bits-1:0]                      pic,
    output logic [kernel_size*kernel_size*pic_bits-1:0] window
);

    localparam int PAD  = kernel_size / 2;      // Zero columns on each side
    localparam int COLS = pic_size + 2 * PAD;   // Stored columns per row

    // Row 0 is the oldest image row, row kernel_size-1 the newest
    logic [pic_bits-1:0] rows [kernel_size][COLS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < kernel_size; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    rows[r][c] <= '0;
                end
            end
        end else if (lb_clear) begin
            // Start of frame, rows above the image read as zero
            for (int r = 0; r < kernel_size; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    rows[r][c] <= '0;
                end
            end
        end else begin
            if (lb_shift) begin
                for (int r = 0; r < kernel_size - 1; r++) begin
                    for (int c = 0; c < COLS; c++) begin
                        rows[r][c] <= rows[r+1][c];   // Move up one row
                    end
                end
                for (int c = 0; c < COLS; c++) begin
                    rows[kernel_size-1][c] <= '0;     // Fresh bottom row, zero until filled
                end
            end
            if (lb_wr)
                rows[kernel_size-1][int'(lb_col) + PAD] <= pic;   // Skip left pad
        end
    end

    // Window whose left edge sits at stored column lb_col
    // Output pixel lb_col is centered in it
    always_comb begin
        for (int i = 0; i < kernel_size; i++) begin
            for (int j = 0; j < kernel_size; j++) begin
                window[(i*kernel_size + j)*pic_bits +: pic_bits] = rows[i][int'(lb_col) + j];
            end
        end
    end

endmodule

// File: conv_pe.sv
`timescale 1ns/1ps

module conv_pe import conv_pkg::*; #(
    parameter int pic_bits    = 8,
    parameter int weight_bits = 8,
    parameter int kernel_size = 5
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        win_valid,
    input  logic [kernel_size*kernel_size*pic_bits-1:0]    window,
    input  logic [kernel_size*kernel_size*weight_bits-1:0] weights,
    input  res_tag_t                                    win_tag,
    output logic                                        res_valid,
    output conv_result_t                                res
);

    localparam int NW        = kernel_size * kernel_size;
    localparam int PROD_BITS = pic_bits + weight_bits;     // Full product width
    localparam int ACC_BITS  = PROD_BITS + $clog2(NW);     // Sum of NW products cannot wrap

    logic [PROD_BITS-1:0] prod_q [NW];           // Stage 1 products
    logic [ACC_BITS-1:0]  sum_d;
    logic [ACC_BITS-1:0]  sum_q;                 // Stage 2 sum
    logic                 v1;
    logic                 v2;
    res_tag_t             tag1;
    res_tag_t             tag2;

    // Reduce the registered products, synthesis builds the adder tree
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < NW; i++) begin
            sum_d = sum_d + ACC_BITS'(prod_q[i]);
        end
    end

    // Valid chain, one bit per stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            v1        <= win_valid;
            v2        <= v1;
            res_valid <= v2;
        end
    end

    // Data path, each stage loads only behind a valid
    always_ff @(posedge clk) begin
        if (win_valid) begin
            for (int i = 0; i < NW; i++) begin
                prod_q[i] <= window[i*pic_bits +: pic_bits] * weights[i*weight_bits +: weight_bits];
            end
            tag1 <= win_tag;
        end
        if (v1) begin
            sum_q <= sum_d;
            tag2  <= tag1;
        end
        if (v2) begin
            res.data <= (sum_q > SAT_MAX) ? RESULT_BITS'(SAT_MAX) : sum_q[RESULT_BITS-1:0];
            res.tag  <= tag2;                    // Address and last flag follow the data
        end
    end

endmodule

// File: conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl import conv_pkg::*; #(
    parameter int kernel_size = 5,
    parameter int pic_size    = 28
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        conv_start,
    input  logic                        w_full,
    input  logic                        pic_valid,
    input  logic                        res_valid,
    input  logic                        res_last,
    output logic                        w_load,
    output logic                        need_pic,
    output logic                        lb_clear,
    output logic                        lb_shift,
    output logic                        lb_wr,
    output logic [$clog2(pic_size)-1:0] lb_col,
    output logic                        win_valid,
    output res_tag_t                    win_tag,
    output logic                        conv_finish
);

    localparam int PAD       = kernel_size / 2;       // Rows of zero padding above and below
    localparam int COL_BITS  = $clog2(pic_size);
    localparam int FILL_BITS = $clog2(pic_size + 1);  // Counts up to pic_size loaded rows

    ctrl_state_t          state;
    logic [COL_BITS-1:0]  col_cnt;       // Fill column or sweep column
    logic [COL_BITS-1:0]  row_cnt;       // Output row being computed
    logic [FILL_BITS-1:0] fill_cnt;      // Image rows loaded so far
    addr_t                addr_cnt;      // Raster address of next window
    logic                 shift_pend;    // Row shift due on this FILL cycle
    logic                 need_pic_q;
    logic                 finish_q;
    logic                 col_last;
    logic                 row_last;
    logic                 pix_take;
    int                   rows_wanted;   // Rows needed for current output row
    logic                 more_now;
    logic                 more_after;

    assign col_last    = (col_cnt == COL_BITS'(pic_size - 1));
    assign row_last    = (row_cnt == COL_BITS'(pic_size - 1));
    assign pix_take    = need_pic_q && pic_valid;          // Pixel accepted this cycle
    assign rows_wanted = int'(row_cnt) + PAD + 1;          // Bottom row is input row row_cnt+PAD

    // Another image row is needed, now or after the row in progress
    assign more_now   = (int'(fill_cnt) < rows_wanted) && (int'(fill_cnt) < pic_size);
    assign more_after = (int'(fill_cnt) + 1 < rows_wanted) && (int'(fill_cnt) + 1 < pic_size);

    assign w_load       = (state == LOAD_W);
    assign lb_clear     = (state == IDLE) && conv_start;
    assign lb_shift     = (state == FILL) && shift_pend;
    assign lb_wr        = (state == FILL) && pix_take;
    assign lb_col       = col_cnt;
    assign win_valid    = (state == CALC);
    assign win_tag.addr = addr_cnt;
    assign win_tag.last = row_last && col_last;            // Bottom right pixel
    assign need_pic     = need_pic_q;
    assign conv_finish  = finish_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            col_cnt    <= '0;
            row_cnt    <= '0;
            fill_cnt   <= '0;
            addr_cnt   <= '0;
            shift_pend <= 1'b0;
            need_pic_q <= 1'b0;
            finish_q   <= 1'b0;
        end else begin
            finish_q <= 1'b0;                              // Single cycle pulse
            case (state)
                IDLE: begin
                    if (conv_start) begin
                        state    <= LOAD_W;
                        col_cnt  <= '0;
                        row_cnt  <= '0;
                        fill_cnt <= '0;
                        addr_cnt <= '0;
                    end
                end
                LOAD_W: begin
                    if (w_full) begin
                        state      <= FILL;
                        shift_pend <= 1'b1;
                    end
                end
                FILL: begin
                    if (shift_pend) begin
                        shift_pend <= 1'b0;
                        if (more_now)
                            need_pic_q <= 1'b1;            // Request the next image row
                        else
                            state <= CALC;                 // Bottom rows stay zero
                    end else if (pix_take) begin
                        if (col_last) begin
                            col_cnt    <= '0;
                            need_pic_q <= 1'b0;
                            fill_cnt   <= fill_cnt + 1'b1;
                            if (more_after)
                                shift_pend <= 1'b1;        // Still prefilling
                            else
                                state <= CALC;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                CALC: begin
                    addr_cnt <= addr_cnt + 1'b1;           // One window per cycle
                    if (col_last) begin
                        col_cnt <= '0;
                        if (row_last) begin
                            state <= DRAIN;
                        end else begin
                            row_cnt    <= row_cnt + 1'b1;
                            state      <= FILL;
                            shift_pend <= 1'b1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    if (res_valid && res_last) begin       // Frame done once the PE empties
                        finish_q <= 1'b1;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: conv_top.sv
`timescale 1ns/1ps

module conv_top import conv_pkg::*; #(
    parameter int pic_bits    = 8,
    parameter int weight_bits = 8,
    parameter int kernel_size = 5,              // Odd, 3 to 7
    parameter int pic_size    = 28
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   conv_start,
    input  logic                   weight_data_valid,
    input  logic [weight_bits-1:0] weight_data,
    input  logic                   pic_valid,
    input  logic [pic_bits-1:0]    pic,
    output logic                   need_pic,
    output logic                   conv_result_valid,
    output logic [RESULT_BITS-1:0] conv_result,
    output addr_t                  conv_result_addr,
    output logic                   conv_finish
);

    localparam int NW = kernel_size * kernel_size;

    logic                        w_load;
    logic                        w_full;
    logic                        lb_clear;
    logic                        lb_shift;
    logic                        lb_wr;
    logic [$clog2(pic_size)-1:0] lb_col;
    logic [NW*pic_bits-1:0]      window;
    logic [NW*weight_bits-1:0]   weights;
    logic                        win_valid;
    res_tag_t                    win_tag;
    conv_result_t                res;

    // Result struct onto the output pins
    assign conv_result      = res.data;
    assign conv_result_addr = res.tag.addr;

    conv_ctrl #(.kernel_size(kernel_size), .pic_size(pic_size)) conv_ctrl_inst (
        .clk, .rst_n, .conv_start, .w_full, .pic_valid,
        .res_valid(conv_result_valid), .res_last(res.tag.last),
        .w_load, .need_pic, .lb_clear, .lb_shift, .lb_wr, .lb_col,
        .win_valid, .win_tag, .conv_finish
    );

    weight_bank #(.weight_bits(weight_bits), .kernel_size(kernel_size)) weight_bank_inst (
        .clk, .rst_n, .w_load, .weight_data_valid, .weight_data, .weights, .w_full
    );

    line_buffer #(.pic_bits(pic_bits), .kernel_size(kernel_size), .pic_size(pic_size))
        line_buffer_inst (
        .clk, .rst_n, .lb_clear, .lb_shift, .lb_wr, .lb_col, .pic, .window
    );

    conv_pe #(.pic_bits(pic_bits), .weight_bits(weight_bits), .kernel_size(kernel_size))
        conv_pe_inst (
        .clk, .rst_n, .win_valid, .window, .weights, .win_tag,
        .res_valid(conv_result_valid), .res
    );

endmodule

// File: conv_top_tb.sv
`timescale 1ns/1ps

module conv_top_tb import conv_pkg::*; ();

    localparam int PIC_BITS    = 8;
    localparam int WEIGHT_BITS = 8;
    localparam int KSIZE       = 3;
    localparam int PSIZE       = 6;
    localparam int NW          = KSIZE * KSIZE;       // Weights per kernel
    localparam int NPIX        = PSIZE * PSIZE;       // Pixels and results per frame
    localparam int GOLD_WORDS  = NW + 2 * NPIX;       // Weights, pixels, expected results
    localparam int CLK_PERIOD  = 20;
    localparam int WATCHDOG_NS = 2 * (NW + NPIX * 4 + NPIX + 50) * CLK_PERIOD;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   conv_start;
    logic                   weight_data_valid;
    logic [WEIGHT_BITS-1:0] weight_data;
    logic                   pic_valid;
    logic [PIC_BITS-1:0]    pic;
    logic                   need_pic;
    logic                   conv_result_valid;
    logic [RESULT_BITS-1:0] conv_result;
    addr_t                  conv_result_addr;
    logic                   conv_finish;

    logic [7:0] golden [0:GOLD_WORDS-1];   // Weights, then pixels, then results
    integer     seed;

    // Monitor state
    bit frame_open  = 1'b0;                 // Between conv_start and conv_finish
    bit finish_due  = 1'b0;                 // Last result seen one cycle back
    int res_cnt     = 0;                    // Results seen in this frame
    int pix_total   = 0;                    // Pixels accepted in this frame
    int row_run     = 0;                    // Pixels accepted in the current request
    int frames_done = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    conv_top #(
        .pic_bits(PIC_BITS), .weight_bits(WEIGHT_BITS), .kernel_size(KSIZE), .pic_size(PSIZE)
    ) conv_top_inst (
        .clk, .rst_n, .conv_start, .weight_data_valid, .weight_data, .pic_valid, .pic,
        .need_pic, .conv_result_valid, .conv_result, .conv_result_addr, .conv_finish
    );

    task automatic end_with_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            end_with_failure();
        end
    endtask

    // Sampled on the rising edge where outputs still hold last cycle's values
    always @(posedge clk) begin
        if (!rst_n) begin
            check_value("need_pic", 32'(need_pic), 32'd0);
            check_value("conv_result_valid", 32'(conv_result_valid), 32'd0);
            check_value("conv_finish", 32'(conv_finish), 32'd0);
        end else begin
            check_value("conv_finish", 32'(conv_finish), 32'(finish_due));   // Single pulse
            finish_due = 1'b0;
            if (conv_finish) begin
                check_value("accepted pixels", 32'(pix_total), 32'(NPIX));
                frame_open  = 1'b0;
                frames_done = frames_done + 1;
            end
            if (!frame_open) begin
                // Quiet between frames
                check_value("need_pic", 32'(need_pic), 32'd0);
                check_value("conv_result_valid", 32'(conv_result_valid), 32'd0);
                if (conv_start) begin
                    frame_open = 1'b1;
                    res_cnt    = 0;
                    pix_total  = 0;
                    row_run    = 0;
                end
            end else begin
                if (need_pic) begin
                    if (row_run >= PSIZE) begin
                        $display("need_pic stayed high after %0d pixels of one row", row_run);
                        end_with_failure();
                    end
                    if (pic_valid) begin                 // Pixel taken this edge
                        row_run   = row_run + 1;
                        pix_total = pix_total + 1;
                    end
                end else begin
                    row_run = 0;
                end
                if (conv_result_valid) begin
                    check_value("conv_result_addr", 32'(conv_result_addr), 32'(res_cnt));
                    check_value("conv_result", 32'(conv_result),
                                32'(golden[NW + NPIX + res_cnt]));
                    if (res_cnt == NPIX - 1)
                        finish_due = 1'b1;               // Pulse expected next cycle
                    res_cnt = res_cnt + 1;
                end
            end
        end
    end

    // Pulse conv_start, then stream the kernel without gaps
    task automatic send_weights();
        conv_start <= 1'b1;
        @(posedge clk);
        conv_start <= 1'b0;
        for (int i = 0; i < NW; i++) begin
            weight_data_valid <= 1'b1;
            weight_data       <= golden[i];
            @(posedge clk);
        end
        weight_data_valid <= 1'b0;
    endtask

    // Offer pixels until all are taken with stalls and junk only in stall mode
    task automatic send_pixels(input bit stall);
        int          idx;
        bit          took;
        logic [31:0] rnd;
        idx = 0;
        pic_valid <= 1'b1;
        pic       <= golden[NW];
        while (idx < NPIX) begin
            @(posedge clk);
            took = pic_valid && need_pic;        // Same rule the DUT uses
            if (took)
                idx = idx + 1;
            rnd = $random(seed);
            if (idx == NPIX) begin
                pic_valid <= 1'b0;
            end else if (stall && took && (idx % PSIZE == 0)) begin
                pic_valid <= 1'b1;               // need_pic is low right after a row
                pic       <= golden[NW + idx] ^ 8'h5a;
            end else if (stall && rnd[1:0] == 2'b00) begin
                pic_valid <= 1'b0;
                pic       <= rnd[15:8];
            end else begin
                pic_valid <= 1'b1;
                pic       <= golden[NW + idx];
            end
        end
    endtask

    task automatic run_frame(input bit stall);
        int target;
        target = frames_done + 1;
        send_weights();
        send_pixels(stall);
        wait (frames_done == target);
        @(posedge clk);
    endtask

    initial begin
        seed = 32'h7c2e_24ad;
        $readmemh("conv_golden.txt", golden);
        rst_n             = 1'b0;
        conv_start        = 1'b0;
        weight_data_valid = 1'b0;
        weight_data       = '0;
        pic_valid         = 1'b0;
        pic               = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);               // Idle cycles where no result may appear
        run_frame(1'b0);                         // Continuous pixels
        repeat (6) @(posedge clk);
        run_frame(1'b1);                         // Random gaps and ignored junk
        repeat (6) @(posedge clk);
        $display("Done: no errors");
        $finish;
    end

    initial begin
        ctrl_state_t hung_state;
        #(WATCHDOG_NS);
        hung_state = conv_top_inst.conv_ctrl_inst.state;
        $display("Timeout after %0d ns, the frames never finished, controller in %s",
                 WATCHDOG_NS, hung_state.name());
        end_with_failure();
    end

endmodule

// File: conv_golden.txt
// One hex byte per line: 9 weights, 36 pixels, 36 expected results, all in raster order
01
02
00
00
01
00
00
00
03
01
02
03
04
05
06
02
00
01
03
00
02
0a
14
05
00
01
04
00
03
02
28
02
01
05
01
00
02
1e
03
01
01
01
01
01
c8
01
05
0c
04
0b
06
40
14
09
11
1a
13
17
1c
7f
0d
07
08
17
35
26
7f
0d
0a
08
0a
0a
57
7f
07
0b
08
02
05
3f
7f

// File: conv_engine.f
conv_pkg.sv
weight_bank.sv
line_buffer.sv
conv_pe.sv
conv_ctrl.sv
conv_top.sv
conv_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the convolution engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module conv_top_tb -f conv_engine.f -o conv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/conv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation passed"
exit 0
